// File: logic/add_sub_unit.sv
`timescale 1ns/1ns

module add_sub_unit #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_data_pkg::operand_t a,
    input  calc_data_pkg::operand_t b,
    input  logic                    sub,    // 1 for a-b
    input  logic                    start,
    output calc_data_pkg::operand_t sum,
    output logic                    carry,  // Carry out, or borrow on subtract
    output logic                    done
);

    logic [OPERAND_W:0] wide;   // Extra bit holds carry or borrow

    // Borrow shows up as the top bit of the wrapped difference
    always_comb begin
        if (sub) begin
            wide = {1'b0, a} - {1'b0, b};
        end else begin
            wide = {1'b0, a} + {1'b0, b};
        end
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            done <= 1'b0;
        end else begin
            done <= start;  // One cycle latency
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sum   <= wide[OPERAND_W-1:0];
            carry <= wide[OPERAND_W];
        end
    end

endmodule

// File: logic/calc_controller.sv
`timescale 1ns/1ns

module calc_controller #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_data_pkg::digit_t   keypad,         // Digit key, 0 when idle
    input  calc_op_pkg::op_code_t   operator,       // One-hot operator key
    input  logic                    equal,          // Equal key
    calc_req_if.ctrl                req,            // Datapath request and response
    output logic                    complete,       // One-cycle result pulse
    output logic                    overflow_out,   // Flag of last result
    output calc_data_pkg::operand_t display         // Last result, held
);
    import calc_data_pkg::*;
    import calc_op_pkg::*;

    calc_state_t state;
    calc_state_t next_state;
    operand_t    opnd_a;        // First operand accumulator
    operand_t    opnd_b;        // Second operand accumulator
    op_code_t    op_q;          // Latched operator
    operand_t    digit_ext;     // Keypad code widened to operand
    logic        digit_ok;      // Legal digit this cycle
    logic        op_ok;         // Operator key is one-hot
    logic        key_idle;      // No key pressed

    assign digit_ext = {{(OPERAND_W-DIGIT_W){1'b0}}, keypad};
    assign digit_ok  = (keypad != NO_KEY) && (keypad <= MAX_DIGIT); // Codes above 9 dropped
    assign op_ok     = operator inside {OP_ADD, OP_SUB, OP_MUL};
    assign key_idle  = (keypad == NO_KEY);

    // Request toward datapath
    assign req.a     = opnd_a;
    assign req.b     = opnd_b;
    assign req.op    = op_q;
    assign req.start = (state == ISSUE);   // Single cycle by construction

    assign complete  = (state == SHOW);

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state <= GET_FIRST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST: begin
                if (key_idle && op_ok) begin
                    next_state = GET_SECOND;    // Operator ends first operand
                end
            end
            GET_SECOND: begin
                if (key_idle && equal) begin
                    next_state = ISSUE;
                end
            end
            ISSUE: begin
                next_state = WAIT_RESULT;
            end
            WAIT_RESULT: begin
                if (req.done) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = GET_FIRST;
            end
            default: begin
                next_state = GET_FIRST;
            end
        endcase
    end

    // Operand entry, operator latch and result capture
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            opnd_a       <= '0;
            opnd_b       <= '0;
            op_q         <= OP_ADD;
            display      <= '0;
            overflow_out <= 1'b0;
        end else begin
            case (state)
                GET_FIRST: begin
                    if (digit_ok) begin
                        opnd_a <= (opnd_a << 3) + (opnd_a << 1) + digit_ext; // x10 plus digit
                    end else if (key_idle && op_ok) begin
                        op_q <= operator;
                    end
                end
                GET_SECOND: begin
                    if (digit_ok) begin
                        opnd_b <= (opnd_b << 3) + (opnd_b << 1) + digit_ext;
                    end
                end
                WAIT_RESULT: begin
                    if (req.done) begin
                        display      <= req.result;     // Valid in SHOW
                        overflow_out <= req.overflow;
                    end
                end
                SHOW: begin
                    opnd_a <= '0;   // Fresh entry for next calculation
                    opnd_b <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // Datapath answers only while a request is outstanding
    a_done_while_waiting: assert property (
        @(posedge clk) disable iff (nRST)
        req.done |-> (state == WAIT_RESULT)
    );

endmodule

// File: logic/calc_data_pkg.sv
package calc_data_pkg;

    // Datapath widths
    localparam int OPERAND_W = 16;              // Operand and result width
    localparam int DIGIT_W   = 4;               // Keypad code width
    localparam int PRODUCT_W = 2 * OPERAND_W;   // Full product width

    // Keypad code, 0 is no key, 1 to 9 are digits
    typedef logic [DIGIT_W-1:0] digit_t;

    // Unsigned operand or result
    typedef logic [OPERAND_W-1:0] operand_t;

    // Partial product accumulator
    typedef logic [PRODUCT_W-1:0] product_t;

    localparam digit_t NO_KEY    = 4'd0;        // Idle keypad
    localparam digit_t MAX_DIGIT = 4'd9;        // Largest legal digit

endpackage

// File: logic/calc_op_pkg.sv
package calc_op_pkg;

    // One-hot operator code from the operator keys
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,    // Addition
        OP_SUB = 3'b010,    // Subtraction
        OP_MUL = 3'b100     // Multiplication
    } op_code_t;

    // Controller sequencing states
    typedef enum logic [2:0] {
        GET_FIRST   = 3'b000,   // Collecting first operand
        GET_SECOND  = 3'b001,   // Collecting second operand
        ISSUE       = 3'b010,   // Start pulse to datapath
        WAIT_RESULT = 3'b011,   // Waiting for done
        SHOW        = 3'b100    // Result shown, complete pulse
    } calc_state_t;

endpackage

// File: logic/calc_req_if.sv
`timescale 1ns/1ns

// Request and response between controller and datapath
interface calc_req_if ();
    import calc_data_pkg::*;
    import calc_op_pkg::*;

    // Request side, driven by controller
    operand_t a;            // First operand
    operand_t b;            // Second operand
    op_code_t op;           // Operator, stable with start
    logic     start;        // One-cycle issue pulse

    // Response side, driven by datapath
    operand_t result;       // Valid with done
    logic     overflow;     // Carry, borrow or product overflow
    logic     done;         // One-cycle completion pulse

    modport ctrl (
        output a, b, op, start,
        input  result, overflow, done
    );

    modport dp (
        input  a, b, op, start,
        output result, overflow, done
    );

endinterface

// File: logic/calc_top.sv
`timescale 1ns/1ns

module calc_top #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_data_pkg::digit_t   keypad,
    input  calc_op_pkg::op_code_t   operator,
    input  logic                    equal,
    output logic                    complete,
    output logic                    overflow,
    output calc_data_pkg::operand_t display
);
    import calc_data_pkg::*;
    import calc_op_pkg::*;

    calc_req_if req ();     // Controller to datapath

    // Dispatcher to add/sub unit
    operand_t add_a;
    operand_t add_b;
    logic     add_sub;
    logic     add_start;
    operand_t add_sum;
    logic     add_carry;
    logic     add_done;

    // Dispatcher to multiplier chain
    logic     mul_valid;
    operand_t mul_a;
    operand_t mul_b;
    op_code_t op_q;

    // Stage links, entry i feeds stage i
    logic     st_valid  [0:OPERAND_W];
    operand_t st_mcand  [0:OPERAND_W];
    operand_t st_mplier [0:OPERAND_W];
    product_t st_acc    [0:OPERAND_W];

    calc_controller #(.OPERAND_W(OPERAND_W)) u_ctrl (
        .clk          (clk),
        .nRST         (nRST),
        .keypad       (keypad),
        .operator     (operator),
        .equal        (equal),
        .req          (req),
        .complete     (complete),
        .overflow_out (overflow),
        .display      (display)
    );

    op_dispatch #(.OPERAND_W(OPERAND_W)) u_disp (
        .clk       (clk),
        .nRST      (nRST),
        .req       (req),
        .add_a     (add_a),
        .add_b     (add_b),
        .add_sub   (add_sub),
        .add_start (add_start),
        .mul_valid (mul_valid),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .op_q      (op_q)
    );

    add_sub_unit #(.OPERAND_W(OPERAND_W)) u_addsub (
        .clk   (clk),
        .nRST  (nRST),
        .a     (add_a),
        .b     (add_b),
        .sub   (add_sub),
        .start (add_start),
        .sum   (add_sum),
        .carry (add_carry),
        .done  (add_done)
    );

    assign st_valid[0]  = mul_valid;
    assign st_mcand[0]  = mul_a;
    assign st_mplier[0] = mul_b;
    assign st_acc[0]    = '0;       // Product starts empty

    // One stage per multiplier bit
    for (genvar i = 0; i < OPERAND_W; i++) begin : g_stage
        mult_stage #(.OPERAND_W(OPERAND_W), .BIT(i)) u_stage (
            .clk        (clk),
            .nRST       (nRST),
            .valid_in   (st_valid[i]),
            .mcand_in   (st_mcand[i]),
            .mplier_in  (st_mplier[i]),
            .acc_in     (st_acc[i]),
            .valid_out  (st_valid[i+1]),
            .mcand_out  (st_mcand[i+1]),
            .mplier_out (st_mplier[i+1]),
            .acc_out    (st_acc[i+1])
        );
    end

    result_collect #(.OPERAND_W(OPERAND_W)) u_collect (
        .clk       (clk),
        .nRST      (nRST),
        .op_q      (op_q),
        .add_done  (add_done),
        .add_carry (add_carry),
        .add_sum   (add_sum),
        .mul_valid (st_valid[OPERAND_W]),
        .mul_acc   (st_acc[OPERAND_W]),
        .req       (req)
    );

endmodule

// File: logic/mult_stage.sv
`timescale 1ns/1ns

module mult_stage #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W,
    parameter int BIT       = 0                         // Multiplier bit for this stage
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic                    valid_in,
    input  calc_data_pkg::operand_t mcand_in,
    input  calc_data_pkg::operand_t mplier_in,
    input  calc_data_pkg::product_t acc_in,
    output logic                    valid_out,
    output calc_data_pkg::operand_t mcand_out,
    output calc_data_pkg::operand_t mplier_out,
    output calc_data_pkg::product_t acc_out
);
    import calc_data_pkg::*;

    product_t addend;   // Multiplicand weighted by this bit

    assign addend = {{OPERAND_W{1'b0}}, mcand_in} << BIT;

    // Valid tracks each product through the chain
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // Payload moves every clock, several products may be in flight
    always_ff @(posedge clk) begin
        mcand_out  <= mcand_in;
        mplier_out <= mplier_in;
        if (mplier_in[BIT]) begin
            acc_out <= acc_in + addend;
        end else begin
            acc_out <= acc_in;      // Bit clear, nothing to add
        end
    end

endmodule

// File: logic/op_dispatch.sv
`timescale 1ns/1ns

module op_dispatch #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W
) (
    input  logic                    clk,
    input  logic                    nRST,
    calc_req_if.dp                  req,        // Request side only
    output calc_data_pkg::operand_t add_a,
    output calc_data_pkg::operand_t add_b,
    output logic                    add_sub,    // 1 selects subtract
    output logic                    add_start,
    output logic                    mul_valid,  // Stage 0 valid
    output calc_data_pkg::operand_t mul_a,      // Multiplicand
    output calc_data_pkg::operand_t mul_b,      // Multiplier
    output calc_op_pkg::op_code_t   op_q        // Op of the request in flight
);
    import calc_op_pkg::*;

    logic is_addsub;
    logic is_mul;

    assign is_addsub = req.op inside {OP_ADD, OP_SUB};
    assign is_mul    = (req.op == OP_MUL);

    // Unit start pulses and op
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            add_start <= 1'b0;
            mul_valid <= 1'b0;
            op_q      <= OP_ADD;
        end else begin
            add_start <= req.start && is_addsub;
            mul_valid <= req.start && is_mul;
            if (req.start) begin
                op_q <= req.op;
            end
        end
    end

    // Operand registers, loaded on start
    always_ff @(posedge clk) begin
        if (req.start) begin
            add_a   <= req.a;
            add_b   <= req.b;
            add_sub <= (req.op == OP_SUB);
            mul_a   <= req.a;
            mul_b   <= req.b;
        end
    end

    // Every issued op reaches exactly one unit
    a_one_unit: assert property (
        @(posedge clk) disable iff (nRST)
        req.start |=> $onehot({add_start, mul_valid})
    );

    // Add result never lands on a product at the collector
    a_no_collision: assert property (
        @(posedge clk) disable iff (nRST)
        add_start |-> !$past(mul_valid, OPERAND_W-1)
    );

endmodule

// File: logic/result_collect.sv
`timescale 1ns/1ns

module result_collect #(
    parameter int OPERAND_W = calc_data_pkg::OPERAND_W
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_op_pkg::op_code_t   op_q,       // Selects overflow rule
    input  logic                    add_done,
    input  logic                    add_carry,
    input  calc_data_pkg::operand_t add_sum,
    input  logic                    mul_valid,  // Last stage valid
    input  calc_data_pkg::product_t mul_acc,    // Full product
    calc_req_if.dp                  req         // Response side only
);
    import calc_op_pkg::*;

    logic mul_hi;       // Product exceeds operand width
    logic next_ovf;

    assign mul_hi = |mul_acc[2*OPERAND_W-1:OPERAND_W];

    always_comb begin
        case (op_q)
            OP_MUL:  next_ovf = mul_hi;
            default: next_ovf = add_carry;  // Carry for add, borrow for sub
        endcase
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            req.done <= 1'b0;
        end else begin
            req.done <= add_done || mul_valid;
        end
    end

    // Result and flag of whichever unit finished
    always_ff @(posedge clk) begin
        if (mul_valid) begin
            req.result   <= mul_acc[OPERAND_W-1:0];    // Low half, modulo 2^16
            req.overflow <= next_ovf;
        end else if (add_done) begin
            req.result   <= add_sum;
            req.overflow <= next_ovf;
        end
    end

    // Units never finish together, and a product matches the op in flight
    a_single_source: assert property (
        @(posedge clk) disable iff (nRST)
        mul_valid |-> !add_done && (op_q == OP_MUL)
    );

endmodule

// File: project.f
+incdir+test
logic/calc_data_pkg.sv
logic/calc_op_pkg.sv
logic/calc_req_if.sv
logic/calc_controller.sv
logic/op_dispatch.sv
logic/add_sub_unit.sv
logic/mult_stage.sv
logic/result_collect.sv
logic/calc_top.sv
test/tb_calc.sv

// File: run.sh
#!/bin/sh
# Builds the calculator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_calc -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_calc)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// File: test/tb_calc_tasks.svh
// Compare a result word with its expected value
task automatic check_result(input string what, input operand_t got, input operand_t exp);
    if (got === exp) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got === exp) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// Expected result and flag from the calculator rules
task automatic predict(input op_code_t op, input operand_t a, input operand_t b,
                       output operand_t res, output logic flag);
    longint unsigned full;
    longint unsigned span;
    span = 64'd1 << OPERAND_W;              // Result range
    case (op)
        OP_SUB: begin
            full = span + 64'(a) - 64'(b);
            flag = (b > a);                 // Borrow
        end
        OP_MUL: begin
            full = 64'(a) * 64'(b);
            flag = (full >= span);          // Upper product bits set
        end
        default: begin
            full = 64'(a) + 64'(b);
            flag = (full >= span);          // Carry out
        end
    endcase
    res = operand_t'(full % span);
endtask

task automatic press_digit(input digit_t d);
    @(negedge clk);
    keypad = d;
    @(negedge clk);
    keypad = NO_KEY;                        // Held for one cycle
endtask

// Decimal digits of keys, most significant first
task automatic enter_number(input int unsigned keys);
    int unsigned digs[$];
    int unsigned rest;
    rest = keys;
    while (rest != 0) begin
        digs.push_front(rest % 10);
        rest = rest / 10;
    end
    foreach (digs[i]) begin
        press_digit(digit_t'(digs[i]));
    end
endtask

task automatic press_operator(input op_code_t op);
    @(negedge clk);
    operator = op;
    @(negedge clk);
    operator = op_code_t'(3'b000);
endtask

task automatic press_equal();
    @(negedge clk);
    equal = 1'b1;
    @(negedge clk);
    equal = 1'b0;
endtask

// Waits for complete, then checks it lasted one cycle
task automatic wait_complete(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < OPERAND_W + 20) begin
        @(negedge clk);
        seen = complete;
        cycles++;
    end
    if (!seen) begin
        fail_count++;
        $display("Timeout at %0t ns: no complete pulse within %0d cycles of equal",
                 $time, OPERAND_W + 20);
    end else begin
        @(negedge clk);
        check_flag("complete after pulse", complete, 1'b0);
    end
endtask

// One calculation from keypad to display
task automatic run_op(input string name, input int unsigned keys_a, input op_code_t op,
                      input int unsigned keys_b, input operand_t exp_res, input logic exp_flag);
    logic seen;
    enter_number(keys_a);
    press_operator(op);
    enter_number(keys_b);
    press_equal();
    wait_complete(seen);
    if (seen) begin
        check_result({name, " display"}, display, exp_res);
        check_flag({name, " overflow"}, overflow, exp_flag);
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (fail_count == errs_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d failed checks", name, fail_count - errs_before);
    end
endtask

// 1 to 3 digits, each 1 to 9
function automatic int unsigned random_operand();
    int unsigned value;
    int unsigned ndig;
    value = 0;
    ndig  = 1 + $urandom % 3;
    repeat (ndig) begin
        value = value * 10 + 1 + $urandom % 9;
    end
    return value;
endfunction

task automatic test_add();
    int errs;
    errs = fail_count;
    run_op("123+45", 123, OP_ADD, 45, 16'd168, 1'b0);
    report_test("addition", errs);
endtask

task automatic test_sub();
    int errs;
    errs = fail_count;
    run_op("900-77", 66436, OP_SUB, 77, 16'd823, 1'b0);     // 66436 wraps to 900, no zero key
    run_op("5-9", 5, OP_SUB, 9, 16'd65532, 1'b1);           // Borrow
    report_test("subtraction", errs);
endtask

task automatic test_mul();
    int errs;
    errs = fail_count;
    run_op("12*34", 12, OP_MUL, 34, 16'd408, 1'b0);
    run_op("300*300", 65836, OP_MUL, 65836, 16'd24464, 1'b1); // 65836 wraps to 300
    report_test("multiplication", errs);
endtask

task automatic test_random();
    int          errs;
    int          k;
    int unsigned a;
    int unsigned b;
    op_code_t    op;
    operand_t    exp_res;
    logic        exp_flag;
    errs = fail_count;
    for (k = 0; k < 10; k++) begin
        a = random_operand();
        b = random_operand();
        case ($urandom % 3)
            0:       op = OP_ADD;
            1:       op = OP_SUB;
            default: op = OP_MUL;
        endcase
        predict(op, operand_t'(a), operand_t'(b), exp_res, exp_flag);
        run_op($sformatf("random %0d", k), a, op, b, exp_res, exp_flag);
    end
    report_test("random operands", errs);
endtask

task automatic test_entry();
    int   errs;
    logic seen;
    errs = fail_count;
    run_op("99999+1", 99999, OP_ADD, 1, 16'd34464, 1'b0);   // 99999 wraps to 34463
    press_digit(4'd1);
    press_digit(4'd12);                     // Code above 9
    press_digit(4'd2);
    press_operator(op_code_t'(3'b011));     // Two keys at once
    press_digit(4'd3);
    press_operator(OP_MUL);
    enter_number(4);
    check_result("display before equal", display, 16'd34464);
    press_equal();
    wait_complete(seen);
    if (seen) begin
        check_result("123*4 display", display, 16'd492);
        check_flag("123*4 overflow", overflow, 1'b0);
    end
    report_test("entry rules", errs);
endtask

// File: test/tb_calc.sv
`timescale 1ns/1ns

module tb_calc;
    import calc_data_pkg::*;
    import calc_op_pkg::*;

    localparam int CLK_HALF    = 4;                             // 8 ns period
    localparam int N_OPS       = 17;                            // Operations over all tests
    localparam int KEYS_PER_OP = 12;                            // Worst case presses per operation
    localparam int OP_CYCLES   = KEYS_PER_OP * 2 + OPERAND_W + 20;
    localparam int WATCHDOG_NS = 2 * N_OPS * OP_CYCLES * 2 * CLK_HALF; // Twice the estimate

    logic     clk;
    logic     nRST;
    digit_t   keypad;
    op_code_t operator;
    logic     equal;
    logic     complete;
    logic     overflow;
    operand_t display;

    int          pass_count;    // Checks that matched
    int          fail_count;    // Mismatches and timeouts

    calc_top #(.OPERAND_W(OPERAND_W)) DUT (
        .clk      (clk),
        .nRST     (nRST),
        .keypad   (keypad),
        .operator (operator),
        .equal    (equal),
        .complete (complete),
        .overflow (overflow),
        .display  (display)
    );

    `include "tb_calc_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Ends a run that stalls somewhere
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t ns: run did not finish within %0d ns", $time, WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        keypad     = NO_KEY;
        operator   = op_code_t'(3'b000);    // No operator key
        equal      = 1'b0;
        nRST       = 1'b1;                  // Reset held from time zero
        pass_count = 0;
        fail_count = 0;
        void'($urandom(11));
        repeat (3) @(negedge clk);
        nRST = 1'b0;

        test_add();
        test_sub();
        test_mul();
        test_random();
        test_entry();

        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
